// ==== hdl/obi_pkg.sv ====
package obi_pkg;

    // address and data width of the bus.
    localparam int OBI_AW = 32;
    localparam int OBI_DW = 32;

    // one enable per data byte.
    localparam int OBI_BEW = OBI_DW / 8;

    // byte address of command address zero, word aligned.
    localparam logic [OBI_AW-1:0] OBI_BASE = 32'h1000_0000;

endpackage

// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

    localparam int CMD_W = 32;

    typedef enum logic [1:0] {
        NOP   = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } cmd_op_e;  // code 3 runs as a nop.

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } cmd_size_e;  // code 3 runs as a word.

    // write form, address counts in words.
    typedef struct packed {
        cmd_op_e     op;
        logic [3:0]  be;
        logic [25:0] word_addr;
    } cmd_wr_t;

    // read form, address counts in bytes.
    typedef struct packed {
        cmd_op_e     op;
        cmd_size_e   size;
        logic [1:0]  spare;
        logic [25:0] byte_addr;
    } cmd_rd_t;

    typedef union packed {
        cmd_wr_t wr;
        cmd_rd_t rd;
    } cmd_word_u;

endpackage

// ==== hdl/obi_req_if.sv ====
`timescale 1ns/1ps

interface obi_req_if;

    logic                         valid;
    logic [obi_pkg::OBI_AW-1:0]   addr;
    logic                         we;
    logic [obi_pkg::OBI_BEW-1:0]  be;
    logic [obi_pkg::OBI_DW-1:0]   wdata;
    cmd_pkg::cmd_size_e           size;
    logic [1:0]                   offset;   // byte lane of a read.
    logic                         take;     // slot consumed this cycle.

    modport dec (
        output valid, addr, we, be, wdata, size, offset,
        input  take
    );

    modport exe (
        input  valid, addr, we, be, wdata, size, offset,
        output take
    );

endinterface

// ==== hdl/obi_rsp_if.sv ====
`timescale 1ns/1ps

interface obi_rsp_if;

    logic                         done;    // rvalid seen.
    logic                         we;
    cmd_pkg::cmd_size_e           size;
    logic [1:0]                   offset;
    logic [obi_pkg::OBI_DW-1:0]   rdata;   // raw bus word.

    modport exe (
        output done, we, size, offset, rdata
    );

    modport res (
        input  done, we, size, offset, rdata
    );

endinterface

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_valid_i,
    input  cmd_pkg::cmd_word_u            cmd_word_i,
    input  logic [obi_pkg::OBI_DW-1:0]    cmd_wdata_i,
    output logic                          cmd_busy_o,
    obi_req_if.dec                        req
);

    logic                         accept;
    logic                         is_rd;
    logic                         is_wr;
    logic                         load;
    logic [obi_pkg::OBI_AW-1:0]   dec_addr;
    logic [obi_pkg::OBI_BEW-1:0]  dec_be;
    logic [1:0]                   dec_offset;
    cmd_pkg::cmd_size_e           dec_size;

    assign cmd_busy_o = req.valid && !req.take;   // a slot being taken can refill.
    assign accept     = cmd_valid_i && !cmd_busy_o;
    assign is_rd      = (cmd_word_i.rd.op == cmd_pkg::READ);
    assign is_wr      = (cmd_word_i.wr.op == cmd_pkg::WRITE);
    assign load       = accept && (is_rd || is_wr);   // nops are swallowed.

    always_comb begin
        dec_addr   = obi_pkg::OBI_BASE + {4'b0, cmd_word_i.wr.word_addr, 2'b00};
        dec_be     = cmd_word_i.wr.be;
        dec_offset = 2'b00;
        dec_size   = cmd_pkg::WORD;
        if (is_rd) begin
            dec_addr   = obi_pkg::OBI_BASE + {6'b0, cmd_word_i.rd.byte_addr[25:2], 2'b00};
            dec_offset = cmd_word_i.rd.byte_addr[1:0];
            dec_size   = cmd_word_i.rd.size;
            case (cmd_word_i.rd.size)
                cmd_pkg::BYTE: begin
                    dec_be = 4'b0001 << dec_offset;
                end
                cmd_pkg::HALF: begin
                    dec_be = 4'b0011 << {dec_offset[1], 1'b0};   // misaligned half goes down.
                end
                default: begin
                    dec_be = 4'b1111;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else if (load) begin
            req.valid <= 1'b1;
        end else if (req.take) begin
            req.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req.addr   <= dec_addr;
            req.we     <= is_wr;
            req.be     <= dec_be;
            req.wdata  <= is_wr ? cmd_wdata_i : '0;
            req.size   <= dec_size;
            req.offset <= dec_offset;
        end
    end

    // the host must respect busy, execute owns take.
    a_no_strobe_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid_i |-> !(req.valid && !req.take))
        else $error("command strobe while decode slot is full");

endmodule

// ==== hdl/obi_master_fsm.sv ====
`timescale 1ns/1ps

module obi_master_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    obi_req_if.exe                        req,
    obi_rsp_if.exe                        rsp,
    output logic                          req_o,
    input  logic                          gnt_i,
    output logic [obi_pkg::OBI_AW-1:0]    addr_o,
    output logic                          we_o,
    output logic [obi_pkg::OBI_BEW-1:0]   be_o,
    output logic [obi_pkg::OBI_DW-1:0]    wdata_o,
    input  logic                          rvalid_i,
    input  logic [obi_pkg::OBI_DW-1:0]    rdata_i
);

    enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID} state_q, state_d;

    cmd_pkg::cmd_size_e size_q;
    logic [1:0]         offset_q;

    assign req.take = (state_q == IDLE) && req.valid;
    assign rsp.done = (state_q == WAIT_RVALID) && rvalid_i;

    assign rsp.we     = we_o;
    assign rsp.size   = size_q;
    assign rsp.offset = offset_q;
    assign rsp.rdata  = rdata_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req.valid) begin
                    state_d = WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                if (gnt_i) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (rvalid_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            req_o   <= 1'b0;
            addr_o  <= '0;
            we_o    <= 1'b0;
            be_o    <= '0;
            wdata_o <= '0;
        end else begin
            state_q <= state_d;
            if (req.take) begin
                req_o   <= 1'b1;
                addr_o  <= req.addr;
                we_o    <= req.we;
                be_o    <= req.be;
                wdata_o <= req.wdata;
            end else if (req_o && gnt_i) begin
                req_o <= 1'b0;   // handshake done, fields stay for the response.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.take) begin
            size_q   <= req.size;
            offset_q <= req.offset;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_o && !gnt_i |=> req_o && $stable(addr_o) && $stable(be_o)
                            && $stable(we_o) && $stable(wdata_o))
        else $error("request fields changed before grant");

    a_rvalid_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i |-> state_q == WAIT_RVALID)
        else $error("rvalid outside of a granted transaction");

endmodule

// ==== hdl/rsp_collect.sv ====
`timescale 1ns/1ps

module rsp_collect (
    input  logic                          clk,
    input  logic                          rst_n,
    obi_rsp_if.res                        rsp,
    output logic                          rsp_valid_o,
    output logic                          rsp_we_o,
    output logic [obi_pkg::OBI_DW-1:0]    rsp_data_o
);

    logic [1:0]                   shift;
    logic [obi_pkg::OBI_DW-1:0]   shifted;
    logic [obi_pkg::OBI_DW-1:0]   aligned;

    always_comb begin
        shift = rsp.offset;
        if (rsp.size == cmd_pkg::HALF) begin
            shift = {rsp.offset[1], 1'b0};
        end
        shifted = rsp.rdata >> {shift, 3'b000};   // byte lanes down to bit zero.
        case (rsp.size)
            cmd_pkg::BYTE: begin
                aligned = {24'b0, shifted[7:0]};
            end
            cmd_pkg::HALF: begin
                aligned = {16'b0, shifted[15:0]};
            end
            default: begin
                aligned = shifted;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= rsp.done;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.done) begin
            rsp_we_o   <= rsp.we;
            rsp_data_o <= rsp.we ? '0 : aligned;   // writes carry no data back.
        end
    end

    // the fsm spends at least one idle cycle between two transactions.
    a_rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid_o |=> !rsp_valid_o)
        else $error("response strobe held two cycles");

endmodule

// ==== hdl/obi_cmd_top.sv ====
`timescale 1ns/1ps

module obi_cmd_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_valid_i,
    input  logic [cmd_pkg::CMD_W-1:0]     cmd_word_i,
    input  logic [obi_pkg::OBI_DW-1:0]    cmd_wdata_i,
    output logic                          cmd_busy_o,
    output logic                          req_o,
    input  logic                          gnt_i,
    output logic [obi_pkg::OBI_AW-1:0]    addr_o,
    output logic                          we_o,
    output logic [obi_pkg::OBI_BEW-1:0]   be_o,
    output logic [obi_pkg::OBI_DW-1:0]    wdata_o,
    input  logic                          rvalid_i,
    input  logic [obi_pkg::OBI_DW-1:0]    rdata_i,
    output logic                          rsp_valid_o,
    output logic                          rsp_we_o,
    output logic [obi_pkg::OBI_DW-1:0]    rsp_data_o
);

    obi_req_if req_if ();
    obi_rsp_if rsp_if ();

    cmd_decode cmd_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_word_i  (cmd_word_i),
        .cmd_wdata_i (cmd_wdata_i),
        .cmd_busy_o  (cmd_busy_o),
        .req         (req_if.dec)
    );

    obi_master_fsm obi_master_fsm_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_if.exe),
        .rsp      (rsp_if.exe),
        .req_o    (req_o),
        .gnt_i    (gnt_i),
        .addr_o   (addr_o),
        .we_o     (we_o),
        .be_o     (be_o),
        .wdata_o  (wdata_o),
        .rvalid_i (rvalid_i),
        .rdata_i  (rdata_i)
    );

    rsp_collect rsp_collect_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp         (rsp_if.res),
        .rsp_valid_o (rsp_valid_o),
        .rsp_we_o    (rsp_we_o),
        .rsp_data_o  (rsp_data_o)
    );

endmodule

// ==== dv/tb_obi_cmd.sv ====
`timescale 1ns/1ps

module tb_obi_cmd;

    localparam int N_CMDS      = 300;
    localparam int CLK_NS      = 4;
    localparam int RESET_CYC   = 16;
    localparam int WATCHDOG_NS = N_CMDS * 20 * CLK_NS + RESET_CYC * CLK_NS;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid_i;
    logic [31:0] cmd_word_i;
    logic [31:0] cmd_wdata_i;
    logic        cmd_busy_o;
    logic        req_o;
    logic        gnt_i;
    logic [31:0] addr_o;
    logic        we_o;
    logic [3:0]  be_o;
    logic [31:0] wdata_o;
    logic        rvalid_i;
    logic [31:0] rdata_i;
    logic        rsp_valid_o;
    logic        rsp_we_o;
    logic [31:0] rsp_data_o;

    logic [31:0] mem [256];   // slave words in the 256-word window above the base.
    logic [31:0] exp_addr_q [$];
    logic        exp_we_q [$];
    logic [3:0]  exp_be_q [$];
    logic [31:0] exp_wdata_q [$];
    logic [1:0]  exp_size_q [$];
    logic [1:0]  exp_off_q [$];
    logic        exp_rwe_q [$];
    logic [31:0] exp_rdata_q [$];
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    int          rsp_count = 0;
    int          nonnop_count = 0;
    bit          rsp_due = 1'b0;   // rvalid seen on the previous edge.
    logic        got_we;
    logic [31:0] got_data;

    obi_cmd_top obi_cmd_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        $display("Test FAILED");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        mismatch_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        fail_cnt++;
    endtask

    function automatic int word_index(input logic [31:0] addr);
        return ((addr - obi_pkg::OBI_BASE) >> 2) & 255;
    endfunction

    // pick the byte lane by offset (halves aligned down) and zero-extend.
    function automatic logic [31:0] expected_read_data(input logic [31:0] word,
                                                       input logic [1:0] size,
                                                       input logic [1:0] off);
        int lane;
        lane = (size == cmd_pkg::HALF) ? (off & 2) : off;
        word = word >> (8 * lane);
        if (size == cmd_pkg::BYTE) begin
            return word & 32'h0000_00ff;
        end else if (size == cmd_pkg::HALF) begin
            return word & 32'h0000_ffff;
        end
        return word;
    endfunction

    task automatic push_request(input logic [31:0] addr, input logic we, input logic [3:0] be,
                                input logic [31:0] wdata, input logic [1:0] size,
                                input logic [1:0] off);
        exp_addr_q.push_back(addr);
        exp_we_q.push_back(we);
        exp_be_q.push_back(be);
        exp_wdata_q.push_back(wdata);
        exp_size_q.push_back(size);
        exp_off_q.push_back(off);
    endtask

    // strobe only after a cycle without a strobe in which busy was seen low.
    task automatic send_command(input logic [31:0] word, input logic [31:0] wdata,
                                input bit loads);
        bit idle;
        @(posedge clk);
        while (cmd_busy_o) @(posedge clk);
        idle = (rsp_count == nonnop_count) && !rsp_valid_o;
        cmd_valid_i <= 1'b1;
        cmd_word_i  <= word;
        cmd_wdata_i <= wdata;
        if (loads) nonnop_count++;
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        if (loads && idle) begin
            @(posedge clk);
            if (req_o) report_failure("req_o rose less than 2 cycles after the command");
            @(posedge clk);
            if (!req_o) report_failure("req_o did not rise 2 cycles after the command");
        end
    endtask

    task automatic serve_grant(output logic [31:0] rd_word);
        logic [31:0] e_addr;
        logic [31:0] e_wdata;
        logic [31:0] e_rdata;
        logic        e_we;
        logic [3:0]  e_be;
        logic [1:0]  e_size;
        logic [1:0]  e_off;
        int          idx;
        int          b;
        idx     = word_index(addr_o);
        rd_word = mem[idx];
        if (exp_addr_q.size() == 0) begin
            report_failure("request granted with no expected command");
        end else begin
            e_addr  = exp_addr_q.pop_front();
            e_we    = exp_we_q.pop_front();
            e_be    = exp_be_q.pop_front();
            e_wdata = exp_wdata_q.pop_front();
            e_size  = exp_size_q.pop_front();
            e_off   = exp_off_q.pop_front();
            if (addr_o !== e_addr)
                report_mismatch($sformatf("addr_o %h, expected %h", addr_o, e_addr));
            if (we_o !== e_we)
                report_mismatch($sformatf("we_o %b, expected %b", we_o, e_we));
            if (be_o !== e_be)
                report_mismatch($sformatf("be_o %b, expected %b", be_o, e_be));
            if (e_we && wdata_o !== e_wdata)
                report_mismatch($sformatf("wdata_o %h, expected %h", wdata_o, e_wdata));
            e_rdata = expected_read_data(mem[word_index(e_addr)], e_size, e_off);
            exp_rwe_q.push_back(e_we);
            exp_rdata_q.push_back(e_we ? 32'h0 : e_rdata);
        end
        if (we_o) begin
            for (b = 0; b < 4; b++) begin
                if (be_o[b]) mem[idx][8*b +: 8] = wdata_o[8*b +: 8];
            end
        end
    endtask

    initial begin : obi_slave
        logic [31:0] h_addr;
        logic [31:0] h_wdata;
        logic [31:0] rd_word;
        logic        h_we;
        logic [3:0]  h_be;
        int          gdelay;
        int          i;
        for (i = 0; i < 256; i++) mem[i] = obi_pkg::OBI_BASE + 4 * i;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (req_o) begin
                h_addr  = addr_o;
                h_we    = we_o;
                h_be    = be_o;
                h_wdata = wdata_o;
                gdelay  = $urandom_range(0, 3);
                for (i = 0; i <= gdelay; i++) begin
                    if (i == gdelay) gnt_i <= 1'b1;
                    @(posedge clk);
                    if (!req_o || addr_o !== h_addr || we_o !== h_we || be_o !== h_be
                        || wdata_o !== h_wdata) report_mismatch("request changed before grant");
                end
                gnt_i <= 1'b0;   // this edge was the handshake.
                serve_grant(rd_word);
                repeat ($urandom_range(1, 3) - 1) @(posedge clk);
                rvalid_i <= 1'b1;
                rdata_i  <= rd_word;
                @(posedge clk);
                rvalid_i <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (rsp_valid_o !== rsp_due)
                report_failure("rsp_valid_o did not follow rvalid_i by one cycle");
            if (rsp_valid_o === 1'b1) begin
                rsp_count++;
                if (exp_rwe_q.size() == 0) begin
                    report_failure("response with no expected entry");
                end else begin
                    got_we   = exp_rwe_q.pop_front();
                    got_data = exp_rdata_q.pop_front();
                    if (rsp_we_o !== got_we)
                        report_mismatch($sformatf("rsp_we_o %b, expected %b", rsp_we_o, got_we));
                    if (rsp_data_o !== got_data)
                        report_mismatch($sformatf("rsp_data_o %h, expected %h", rsp_data_o,
                                                  got_data));
                end
            end
            rsp_due = rvalid_i;
        end
    end

    initial begin : stimulus
        logic [31:0] word;
        logic [31:0] wdata;
        logic [31:0] rnd;
        logic [25:0] wa;
        logic [25:0] ba;
        logic [3:0]  be;
        logic [1:0]  size;
        logic [3:0]  rd_be;
        int          kind;
        int          n;
        rst_n       = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_word_i  = '0;
        cmd_wdata_i = '0;
        gnt_i       = 1'b0;
        rvalid_i    = 1'b0;
        rdata_i     = '0;
        void'($urandom(90));
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (req_o !== 1'b0 || cmd_busy_o !== 1'b0 || rsp_valid_o !== 1'b0)
            report_mismatch("req_o, cmd_busy_o or rsp_valid_o not low after reset");
        for (n = 0; n < N_CMDS; n++) begin
            kind  = $urandom_range(0, 9);
            wdata = $urandom;
            rnd   = $urandom;
            wa    = $urandom_range(0, 255);
            ba    = $urandom_range(0, 1023);
            be    = $urandom_range(0, 15);
            size  = $urandom_range(0, 3);
            repeat ($urandom_range(0, 2)) @(posedge clk);
            if (kind < 4) begin
                word = {cmd_pkg::WRITE, be, wa};
                push_request(obi_pkg::OBI_BASE + wa * 4, 1'b1, be, wdata, cmd_pkg::WORD, 2'b00);
                send_command(word, wdata, 1'b1);
            end else if (kind < 8) begin
                word = {cmd_pkg::READ, size, rnd[1:0], ba};   // spare bits are random.
                if (size == cmd_pkg::BYTE) rd_be = 4'b0001 << ba[1:0];
                else if (size == cmd_pkg::HALF) rd_be = 4'b0011 << (ba[1:0] & 2'b10);
                else rd_be = 4'b1111;
                push_request(obi_pkg::OBI_BASE + (ba & ~26'h3), 1'b0, rd_be, 32'h0, size, ba[1:0]);
                send_command(word, wdata, 1'b1);
            end else begin
                word = {(kind == 8) ? 2'd0 : 2'd3, rnd[29:0]};   // both nop codes.
                send_command(word, wdata, 1'b0);
            end
        end
        while (rsp_count < nonnop_count) @(posedge clk);
        repeat (8) @(posedge clk);
        if (rsp_count != nonnop_count)
            report_failure($sformatf("%0d responses for %0d non-nop commands", rsp_count, nonnop_count));
        if (exp_addr_q.size() != 0 || exp_rwe_q.size() != 0)
            report_failure("expected entries left over at the end");
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/obi_pkg.sv
hdl/cmd_pkg.sv
hdl/obi_req_if.sv
hdl/obi_rsp_if.sv
hdl/cmd_decode.sv
hdl/obi_master_fsm.sv
hdl/rsp_collect.sv
hdl/obi_cmd_top.sv
dv/tb_obi_cmd.sv
